/* source/lcs_macros.svh */
// Lifecycle security subsystem widths and register map

`ifndef LCS_MACROS_SVH
`define LCS_MACROS_SVH

// Widths
`define LCS_LC_STATE_W      5
`define LCS_ERR_SRC_W       4
`define LCS_WB_ADDR_W       8

// Wishbone register byte offsets
`define LCS_REG_CTRL        8'h00   // Bit 0 manufacturing debug enable
`define LCS_REG_UNLOCK_LO   8'h04
`define LCS_REG_UNLOCK_HI   8'h08
`define LCS_REG_ERR_MASK    8'h0C
`define LCS_REG_ERR_STATUS  8'h10   // Write one to clear
`define LCS_REG_SEC_STATE   8'h14   // Read only

`endif

/* source/lcs_pkg.sv */
// Lifecycle security types

`include "lcs_macros.svh"

package lcs_pkg;

    // Lifecycle state as reported by OTP
    typedef enum logic [`LCS_LC_STATE_W-1:0] {
        lc_st_raw            = 5'h00,
        lc_st_test_locked0   = 5'h01,
        lc_st_test_locked1   = 5'h02,
        lc_st_test_locked2   = 5'h03,
        lc_st_test_locked3   = 5'h04,
        lc_st_test_locked4   = 5'h05,
        lc_st_test_locked5   = 5'h06,
        lc_st_test_locked6   = 5'h07,
        lc_st_test_unlocked0 = 5'h08,
        lc_st_test_unlocked1 = 5'h09,
        lc_st_test_unlocked2 = 5'h0A,
        lc_st_test_unlocked3 = 5'h0B,
        lc_st_test_unlocked4 = 5'h0C,
        lc_st_test_unlocked5 = 5'h0D,
        lc_st_test_unlocked6 = 5'h0E,
        lc_st_test_unlocked7 = 5'h0F,
        lc_st_dev            = 5'h10,
        lc_st_prod           = 5'h11,
        lc_st_prod_end       = 5'h12,
        lc_st_rma            = 5'h13,
        lc_st_scrap          = 5'h14,
        lc_st_invalid        = 5'h1F   // Catch-all for other codes
    } lc_state_e;

    // Translator FSM states
    typedef enum logic [2:0] {
        tr_reset           = 3'd0,
        tr_idle            = 3'd1,
        tr_non_debug       = 3'd2,
        tr_unprov_debug    = 3'd3,
        tr_manuf_non_debug = 3'd4,
        tr_manuf_debug     = 3'd5,
        tr_prod_non_debug  = 3'd6,
        tr_prod_debug      = 3'd7
    } trans_state_e;

    // Device lifecycle seen by the security logic
    typedef enum logic [1:0] {
        dlc_unprovisioned = 2'b00,
        dlc_manufacturing = 2'b01,
        dlc_production    = 2'b11
    } device_lifecycle_e;

endpackage

/* source/lcs_err_agg.sv */
// Fatal error aggregator

`timescale 1ns/100ps
`include "lcs_macros.svh"

module lcs_err_agg (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`LCS_ERR_SRC_W-1:0] fatal_err_i,   // Raw error sources
    input  logic [`LCS_ERR_SRC_W-1:0] err_mask_i,    // 1 hides the source
    input  logic [`LCS_ERR_SRC_W-1:0] err_clr_i,     // Clear pulse per bit
    output logic [`LCS_ERR_SRC_W-1:0] err_status_o,
    output logic                      state_error_o
);

    logic [`LCS_ERR_SRC_W-1:0] status_d;
    logic [`LCS_ERR_SRC_W-1:0] unmasked;

    // Set wins over clear in the same cycle
    assign status_d = (err_status_o & ~err_clr_i) | fatal_err_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_status_o <= '0;
        end else begin
            err_status_o <= status_d;
        end
    end

    // Mask only affects the state error, status stays visible
    assign unmasked      = err_status_o & ~err_mask_i;
    assign state_error_o = |unmasked;

endmodule

/* source/lcs_dbg_regs.sv */
// Debug control register block, Wishbone classic slave

`timescale 1ns/100ps
`include "lcs_macros.svh"

module lcs_dbg_regs (
    input  logic                       clk,
    input  logic                       rst_n,
    // Wishbone slave
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [`LCS_WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [31:0]                wb_dat_i,
    input  logic [3:0]                 wb_sel_i,
    output logic [31:0]                wb_dat_o,
    output logic                       wb_ack_o,
    // Status in
    input  logic [`LCS_ERR_SRC_W-1:0]  err_status_i,
    input  lcs_pkg::device_lifecycle_e sec_lifecycle_i,
    input  logic                       sec_debug_locked_i,
    // Control out
    output logic                       manuf_dbg_en_o,
    output logic [63:0]                unlock_level_o,
    output logic [`LCS_ERR_SRC_W-1:0]  err_mask_o,
    output logic [`LCS_ERR_SRC_W-1:0]  err_clr_o
);

    logic        req;
    logic        wr_req;
    logic [31:0] rd_word;        // Current value at the addressed offset
    logic [31:0] wr_word;        // rd_word with the selected bytes replaced
    logic [31:0] unlock_lo_q;
    logic [31:0] unlock_hi_q;

    // Replace the bytes enabled by sel
    function automatic logic [31:0] byte_merge(
        input logic [31:0] old_val,
        input logic [31:0] new_val,
        input logic [3:0]  sel
    );
        logic [31:0] res;
        res = old_val;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                res[8*b +: 8] = new_val[8*b +: 8];
            end
        end
        return res;
    endfunction

    assign req    = wb_cyc_i && wb_stb_i && !wb_ack_o;   // New request only
    assign wr_req = req && wb_we_i;

    always_comb begin
        case (wb_adr_i)
            `LCS_REG_CTRL:       rd_word = {31'b0, manuf_dbg_en_o};
            `LCS_REG_UNLOCK_LO:  rd_word = unlock_lo_q;
            `LCS_REG_UNLOCK_HI:  rd_word = unlock_hi_q;
            `LCS_REG_ERR_MASK:   rd_word = {{(32-`LCS_ERR_SRC_W){1'b0}}, err_mask_o};
            `LCS_REG_ERR_STATUS: rd_word = {{(32-`LCS_ERR_SRC_W){1'b0}}, err_status_i};
            `LCS_REG_SEC_STATE:  rd_word = {29'b0, sec_debug_locked_i, sec_lifecycle_i};
            default:             rd_word = 32'b0;           // Unmapped
        endcase
    end

    assign wr_word        = byte_merge(rd_word, wb_dat_i, wb_sel_i);
    assign unlock_level_o = {unlock_hi_q, unlock_lo_q};

    // Ack one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack_o <= 1'b0;
        end else begin
            wb_ack_o <= req;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_o <= rd_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            manuf_dbg_en_o <= 1'b0;
            unlock_lo_q    <= 32'b0;
            unlock_hi_q    <= 32'b0;
            err_mask_o     <= '0;
            err_clr_o      <= '0;
        end else begin
            err_clr_o <= '0;                        // Single-cycle pulse
            if (wr_req) begin
                case (wb_adr_i)
                    `LCS_REG_CTRL:      manuf_dbg_en_o <= wr_word[0];
                    `LCS_REG_UNLOCK_LO: unlock_lo_q    <= wr_word;
                    `LCS_REG_UNLOCK_HI: unlock_hi_q    <= wr_word;
                    `LCS_REG_ERR_MASK:  err_mask_o     <= wr_word[`LCS_ERR_SRC_W-1:0];
                    `LCS_REG_ERR_STATUS: begin
                        if (wb_sel_i[0]) begin
                            err_clr_o <= wb_dat_i[`LCS_ERR_SRC_W-1:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

/* source/lcs_sec_translator.sv */
// Lifecycle to security state translator

`timescale 1ns/100ps

module lcs_sec_translator (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       otp_valid_i,
    input  lcs_pkg::lc_state_e         otp_lc_state_i,
    input  logic                       lc_prog_req_i,
    input  lcs_pkg::lc_state_e         lc_prog_state_i,
    input  logic                       state_error_i,
    input  logic                       manuf_dbg_en_i,
    input  logic [63:0]                unlock_level_i,
    output lcs_pkg::device_lifecycle_e sec_lifecycle_o,
    output logic                       sec_debug_locked_o
);
    import lcs_pkg::*;

    trans_state_e      state_q;
    trans_state_e      state_d;
    lc_state_e         otp_state_q;      // Latched OTP report
    device_lifecycle_e lifecycle_d;
    logic              locked_d;
    logic              scrap_req;
    logic              force_lock;

    assign scrap_req  = lc_prog_req_i && (lc_prog_state_i == lc_st_scrap);
    assign force_lock = scrap_req || state_error_i;

    // Everything falls back to reset while OTP is not valid
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q            <= tr_reset;
            otp_state_q        <= lc_st_raw;
            sec_lifecycle_o    <= dlc_production;
            sec_debug_locked_o <= 1'b1;
        end else if (otp_valid_i) begin
            state_q            <= state_d;
            otp_state_q        <= otp_lc_state_i;
            sec_lifecycle_o    <= lifecycle_d;
            sec_debug_locked_o <= locked_d;
        end else begin
            state_q            <= tr_reset;
            otp_state_q        <= lc_st_raw;
            sec_lifecycle_o    <= dlc_production;
            sec_debug_locked_o <= 1'b1;
        end
    end

    always_comb begin
        state_d     = state_q;
        lifecycle_d = dlc_production;   // Locked production unless a state says otherwise
        locked_d    = 1'b1;
        case (state_q)
            tr_reset: begin
                state_d = tr_idle;          // Only taken while valid
            end
            tr_idle: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else begin
                    case (otp_state_q)
                        lc_st_raw, lc_st_test_locked0, lc_st_test_locked1,
                        lc_st_test_locked2, lc_st_test_locked3, lc_st_test_locked4,
                        lc_st_test_locked5, lc_st_test_locked6: begin
                            state_d = tr_non_debug;
                        end
                        lc_st_test_unlocked0, lc_st_test_unlocked1, lc_st_test_unlocked2,
                        lc_st_test_unlocked3, lc_st_test_unlocked4, lc_st_test_unlocked5,
                        lc_st_test_unlocked6, lc_st_test_unlocked7: begin
                            state_d = tr_unprov_debug;
                        end
                        lc_st_dev:                  state_d = tr_manuf_non_debug;
                        lc_st_prod, lc_st_prod_end: state_d = tr_prod_non_debug;
                        lc_st_rma:                  state_d = tr_prod_debug;
                        default:                    state_d = tr_non_debug;  // Scrap, bad codes
                    endcase
                end
            end
            tr_non_debug: begin
                state_d = tr_non_debug;     // Left only when valid drops
            end
            tr_unprov_debug: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else begin
                    lifecycle_d = dlc_unprovisioned;
                    locked_d    = 1'b0;
                end
            end
            tr_manuf_non_debug: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else begin
                    lifecycle_d = dlc_manufacturing;
                    if (manuf_dbg_en_i) begin
                        state_d = tr_manuf_debug;
                    end
                end
            end
            tr_manuf_debug: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else begin
                    lifecycle_d = dlc_manufacturing;
                    locked_d    = 1'b0;
                end
            end
            tr_prod_non_debug: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else if (unlock_level_i != '0) begin
                    state_d = tr_prod_debug;  // Any nonzero level unlocks
                end
            end
            tr_prod_debug: begin
                if (force_lock) begin
                    state_d = tr_non_debug;
                end else begin
                    locked_d = 1'b0;        // Holds here
                end
            end
            default: begin
                state_d = tr_non_debug;
            end
        endcase
    end

endmodule

/* source/lcs_top.sv */
// Lifecycle security subsystem top

`timescale 1ns/100ps
`include "lcs_macros.svh"

module lcs_top (
    input  logic                       clk,
    input  logic                       rst_n,
    // OTP report
    input  logic                       otp_valid_i,
    input  lcs_pkg::lc_state_e         otp_lc_state_i,
    // Lifecycle controller programming request
    input  logic                       lc_prog_req_i,
    input  lcs_pkg::lc_state_e         lc_prog_state_i,
    // Fatal errors
    input  logic [`LCS_ERR_SRC_W-1:0]  fatal_err_i,
    // Wishbone slave
    input  logic                       wb_cyc_i,
    input  logic                       wb_stb_i,
    input  logic                       wb_we_i,
    input  logic [`LCS_WB_ADDR_W-1:0]  wb_adr_i,
    input  logic [31:0]                wb_dat_i,
    input  logic [3:0]                 wb_sel_i,
    output logic [31:0]                wb_dat_o,
    output logic                       wb_ack_o,
    // Security state
    output lcs_pkg::device_lifecycle_e sec_lifecycle_o,
    output logic                       sec_debug_locked_o
);

    logic                      manuf_dbg_en;
    logic [63:0]               unlock_level;
    logic [`LCS_ERR_SRC_W-1:0] err_mask;
    logic [`LCS_ERR_SRC_W-1:0] err_clr;
    logic [`LCS_ERR_SRC_W-1:0] err_status;
    logic                      state_error;

    lcs_dbg_regs u_dbg_regs (
        .clk                (clk),
        .rst_n              (rst_n),
        .wb_cyc_i           (wb_cyc_i),
        .wb_stb_i           (wb_stb_i),
        .wb_we_i            (wb_we_i),
        .wb_adr_i           (wb_adr_i),
        .wb_dat_i           (wb_dat_i),
        .wb_sel_i           (wb_sel_i),
        .wb_dat_o           (wb_dat_o),
        .wb_ack_o           (wb_ack_o),
        .err_status_i       (err_status),
        .sec_lifecycle_i    (sec_lifecycle_o),      // Readback of the live state
        .sec_debug_locked_i (sec_debug_locked_o),
        .manuf_dbg_en_o     (manuf_dbg_en),
        .unlock_level_o     (unlock_level),
        .err_mask_o         (err_mask),
        .err_clr_o          (err_clr)
    );

    lcs_err_agg u_err_agg (
        .clk           (clk),
        .rst_n         (rst_n),
        .fatal_err_i   (fatal_err_i),
        .err_mask_i    (err_mask),
        .err_clr_i     (err_clr),
        .err_status_o  (err_status),
        .state_error_o (state_error)
    );

    lcs_sec_translator u_sec_translator (
        .clk                (clk),
        .rst_n              (rst_n),
        .otp_valid_i        (otp_valid_i),
        .otp_lc_state_i     (otp_lc_state_i),
        .lc_prog_req_i      (lc_prog_req_i),
        .lc_prog_state_i    (lc_prog_state_i),
        .state_error_i      (state_error),
        .manuf_dbg_en_i     (manuf_dbg_en),
        .unlock_level_i     (unlock_level),
        .sec_lifecycle_o    (sec_lifecycle_o),
        .sec_debug_locked_o (sec_debug_locked_o)
    );

endmodule

/* bench/lcs_tb.sv */
// Lifecycle security subsystem testbench

`timescale 1ns/100ps
`include "lcs_macros.svh"

module lcs_tb;
    import lcs_pkg::*;

    localparam int ACK_TIMEOUT   = 20;    // Cycles to wait for wb ack
    localparam int STATE_TIMEOUT = 50;    // Cycles to wait for an output pair

    logic                      clk;
    logic                      rst_n;
    logic                      otp_valid;
    lc_state_e                 otp_lc_state;
    logic                      lc_prog_req;
    lc_state_e                 lc_prog_state;
    logic [`LCS_ERR_SRC_W-1:0] fatal_err;
    logic                      wb_cyc;
    logic                      wb_stb;
    logic                      wb_we;
    logic [`LCS_WB_ADDR_W-1:0] wb_adr;
    logic [31:0]               wb_dat_w;
    logic [3:0]                wb_sel;
    logic [31:0]               wb_dat_r;
    logic                      wb_ack;
    device_lifecycle_e         sec_lifecycle;
    logic                      sec_debug_locked;

    int          errors;
    int          checks;
    logic [31:0] seed;

    lcs_top lcs_top_i (
        .clk                (clk),
        .rst_n              (rst_n),
        .otp_valid_i        (otp_valid),
        .otp_lc_state_i     (otp_lc_state),
        .lc_prog_req_i      (lc_prog_req),
        .lc_prog_state_i    (lc_prog_state),
        .fatal_err_i        (fatal_err),
        .wb_cyc_i           (wb_cyc),
        .wb_stb_i           (wb_stb),
        .wb_we_i            (wb_we),
        .wb_adr_i           (wb_adr),
        .wb_dat_i           (wb_dat_w),
        .wb_sel_i           (wb_sel),
        .wb_dat_o           (wb_dat_r),
        .wb_ack_o           (wb_ack),
        .sec_lifecycle_o    (sec_lifecycle),
        .sec_debug_locked_o (sec_debug_locked)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Multiplier and increment from Numerical Recipes
    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    // SEC_STATE has locked in bit 2 and lifecycle in bits 1:0
    function automatic logic [31:0] sec_word(input device_lifecycle_e lc, input logic locked);
        return {29'b0, locked, lc};
    endfunction

    task automatic check_word(input string test, input string item,
                              input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s (%s): expected 0x%0h, actual 0x%0h", test, item, exp, act);
        end
    endtask

    task automatic wait_ack(input logic [`LCS_WB_ADDR_W-1:0] addr);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (wb_ack !== 1'b1 && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (wb_ack !== 1'b1) begin
            errors++;
            $display("Wishbone access to 0x%0h got no ack in %0d cycles", addr, ACK_TIMEOUT);
        end
    endtask

    task automatic wb_write(input logic [`LCS_WB_ADDR_W-1:0] addr, input logic [31:0] data);
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= 1'b1;
        wb_adr   <= addr;
        wb_dat_w <= data;
        wb_sel   <= 4'hF;
        wait_ack(addr);
        @(posedge clk);
        wb_cyc <= 1'b0;   // Drop the cycle after ack
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_read(input logic [`LCS_WB_ADDR_W-1:0] addr, output logic [31:0] data);
        @(posedge clk);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we  <= 1'b0;
        wb_adr <= addr;
        wb_sel <= 4'hF;
        wait_ack(addr);
        data = wb_dat_r;
        @(posedge clk);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
    endtask

    task automatic wait_state(input string test, input device_lifecycle_e exp_lc,
                              input logic exp_locked);
        int cnt;
        cnt = 0;
        @(negedge clk);
        while ((sec_lifecycle !== exp_lc || sec_debug_locked !== exp_locked)
               && cnt < STATE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        checks++;
        if (sec_lifecycle !== exp_lc || sec_debug_locked !== exp_locked) begin
            errors++;
            $display("[ERROR] %s (outputs): expected lifecycle %0h locked %0b, actual %0h %0b",
                     test, exp_lc, exp_locked, sec_lifecycle, sec_debug_locked);
        end
    endtask

    task automatic check_sec_state(input string test, input device_lifecycle_e lc,
                                   input logic locked);
        logic [31:0] rd;
        wb_read(`LCS_REG_SEC_STATE, rd);
        check_word(test, "SEC_STATE", sec_word(lc, locked), rd);
    endtask

    // Drop valid, present a new code, raise valid, let the outputs settle
    task automatic restart_otp(input lc_state_e code);
        @(posedge clk);
        otp_valid <= 1'b0;
        @(posedge clk);
        otp_lc_state <= code;
        otp_valid    <= 1'b1;
        repeat (3) @(posedge clk);   // Idle, decode, output register
    endtask

    task automatic pulse_error(input logic [`LCS_ERR_SRC_W-1:0] bits);
        @(posedge clk);
        fatal_err <= bits;
        @(posedge clk);
        fatal_err <= '0;
    endtask

    task automatic test_reset_defaults();
        string       name;
        logic [31:0] rd;
        name = "reset_defaults";
        wait_state(name, dlc_production, 1'b1);
        wb_read(`LCS_REG_CTRL, rd);
        check_word(name, "CTRL", 32'h0, rd);
        wb_read(`LCS_REG_UNLOCK_LO, rd);
        check_word(name, "UNLOCK_LO", 32'h0, rd);
        wb_read(`LCS_REG_UNLOCK_HI, rd);
        check_word(name, "UNLOCK_HI", 32'h0, rd);
        wb_read(`LCS_REG_ERR_MASK, rd);
        check_word(name, "ERR_MASK", 32'h0, rd);
        wb_read(`LCS_REG_ERR_STATUS, rd);
        check_word(name, "ERR_STATUS", 32'h0, rd);
        check_sec_state(name, dlc_production, 1'b1);
    endtask

    task automatic decode_case(input logic [4:0] code, input device_lifecycle_e exp_lc,
                               input logic exp_locked);
        restart_otp(lc_state_e'(code));
        wait_state("decode_table", exp_lc, exp_locked);
        check_sec_state("decode_table", exp_lc, exp_locked);
    endtask

    task automatic test_decode_table();
        decode_case(5'h00, dlc_production, 1'b1);      // raw
        decode_case(5'h01, dlc_production, 1'b1);      // test_locked0
        decode_case(5'h04, dlc_production, 1'b1);
        decode_case(5'h07, dlc_production, 1'b1);      // test_locked6
        decode_case(5'h08, dlc_unprovisioned, 1'b0);   // test_unlocked0
        decode_case(5'h0D, dlc_unprovisioned, 1'b0);
        decode_case(5'h0F, dlc_unprovisioned, 1'b0);   // test_unlocked7
        decode_case(5'h10, dlc_manufacturing, 1'b1);   // dev
        decode_case(5'h11, dlc_production, 1'b1);      // prod
        decode_case(5'h12, dlc_production, 1'b1);      // prod_end
        decode_case(5'h13, dlc_production, 1'b0);      // rma
        decode_case(5'h14, dlc_production, 1'b1);      // scrap
        decode_case(5'h1A, dlc_production, 1'b1);      // Not a defined code
    endtask

    task automatic test_manuf_debug();
        string name;
        name = "manuf_debug";
        restart_otp(lc_st_dev);
        wait_state(name, dlc_manufacturing, 1'b1);
        wb_write(`LCS_REG_CTRL, 32'h1);
        wait_state(name, dlc_manufacturing, 1'b0);
        check_sec_state(name, dlc_manufacturing, 1'b0);
        wb_write(`LCS_REG_CTRL, 32'h0);
    endtask

    task automatic test_prod_unlock();
        string       name;
        logic [31:0] rd;
        logic [31:0] level;
        name = "prod_unlock";
        restart_otp(lc_st_prod);
        wait_state(name, dlc_production, 1'b1);
        repeat (5) @(posedge clk);
        wait_state(name, dlc_production, 1'b1);   // Zero level keeps it locked
        level = lcg_next();
        if (level == 32'h0) begin
            level = 32'h1;
        end
        wb_write(`LCS_REG_UNLOCK_HI, level);
        wait_state(name, dlc_production, 1'b0);
        wb_read(`LCS_REG_UNLOCK_HI, rd);
        check_word(name, "UNLOCK_HI", level, rd);
        wb_read(`LCS_REG_UNLOCK_LO, rd);
        check_word(name, "UNLOCK_LO", 32'h0, rd);
        check_sec_state(name, dlc_production, 1'b0);
        wb_write(`LCS_REG_UNLOCK_HI, 32'h0);
    endtask

    task automatic test_fatal_errors();
        string       name;
        logic [31:0] rd;
        name = "fatal_errors";
        restart_otp(lc_st_test_unlocked0);
        wait_state(name, dlc_unprovisioned, 1'b0);
        wb_write(`LCS_REG_ERR_MASK, 32'h1);       // Hide source 0
        pulse_error(4'b0001);
        repeat (3) @(posedge clk);
        wait_state(name, dlc_unprovisioned, 1'b0);
        wb_read(`LCS_REG_ERR_STATUS, rd);
        check_word(name, "ERR_STATUS", 32'h1, rd);
        pulse_error(4'b0010);
        wait_state(name, dlc_production, 1'b1);
        wb_write(`LCS_REG_ERR_STATUS, 32'hF);
        wb_read(`LCS_REG_ERR_STATUS, rd);
        check_word(name, "ERR_STATUS", 32'h0, rd);
        repeat (3) @(posedge clk);
        wait_state(name, dlc_production, 1'b1);   // non_debug holds
        check_sec_state(name, dlc_production, 1'b1);
        wb_write(`LCS_REG_ERR_MASK, 32'h0);
    endtask

    task automatic test_scrap_request();
        string name;
        name = "scrap_request";
        restart_otp(lc_st_test_unlocked3);
        wait_state(name, dlc_unprovisioned, 1'b0);
        @(posedge clk);
        lc_prog_req   <= 1'b1;
        lc_prog_state <= lc_st_scrap;
        @(posedge clk);
        lc_prog_req   <= 1'b0;
        lc_prog_state <= lc_st_raw;
        wait_state(name, dlc_production, 1'b1);
        check_sec_state(name, dlc_production, 1'b1);
    endtask

    initial begin
        errors        = 0;
        checks        = 0;
        seed          = 32'd98946;
        rst_n         = 1'b0;
        otp_valid     = 1'b0;
        otp_lc_state  = lc_st_raw;
        lc_prog_req   = 1'b0;
        lc_prog_state = lc_st_raw;
        fatal_err     = '0;
        wb_cyc        = 1'b0;
        wb_stb        = 1'b0;
        wb_we         = 1'b0;
        wb_adr        = '0;
        wb_dat_w      = 32'h0;
        wb_sel        = 4'h0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        test_reset_defaults();
        test_decode_table();
        test_manuf_debug();
        test_prod_unlock();
        test_fatal_errors();
        test_scrap_request();

        $display("Run complete: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+source
source/lcs_pkg.sv
source/lcs_err_agg.sv
source/lcs_dbg_regs.sv
source/lcs_sec_translator.sv
source/lcs_top.sv
bench/lcs_tb.sv

/* Makefile */
# Verilator build for the lifecycle security subsystem

VERILATOR ?= verilator
VFLAGS    ?= --timing --timescale 1ns/100ps
TOP       ?= lcs_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
